//--- logic/gcu_bus_ctrl.sv
////////////////////////////////////////
// gcu bus controller, decodes cpu ops and
// sequences RAM access with ack stall
////////////////////////////////////////
`timescale 1ns/100ps
`include "gcu_defs.svh"

module gcu_bus_ctrl (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                op_select_reg,
    input  logic                op_write_reg,
    input  logic                op_write_ram,
    input  logic                op_read_ram_h,
    input  logic                op_read_ram_l,
    input  logic                op_set_ram_ptr,
    input  gcu_pkg::vram_word_t din,
    output gcu_pkg::vram_word_t dout,
    output logic                ack,
    output gcu_pkg::vram_addr_t ram_addr,
    output gcu_pkg::vram_word_t ram_din,
    output logic                ram_we,
    input  gcu_pkg::vram_word_t ram_dout,
    output gcu_pkg::reg_num_t   reg_num,
    output gcu_pkg::vram_word_t reg_wr_data,
    output logic                reg_we
);

    localparam logic [2:0] rd_last = 3'(`GCU_READ_WAIT);

    logic [5:0]          op_vec;
    logic [5:0]          last_op;
    logic                op_new;
    logic                rd_op;
    logic [2:0]          step;
    logic [2:0]          step_cur;
    gcu_pkg::vram_word_t ptr;
    gcu_pkg::vram_addr_t ptr_addr;

    assign op_vec = {op_select_reg, op_write_reg, op_set_ram_ptr,
                     op_write_ram, op_read_ram_h, op_read_ram_l};
    assign op_new = (op_vec != last_op);
    assign rd_op  = op_read_ram_h | op_read_ram_l;

    // any change of op restarts the sequence
    assign step_cur = op_new ? 3'd0 : step;
    assign ptr_addr = gcu_pkg::vram_addr_t'(ptr & `GCU_PTR_MASK);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            last_op <= '0;
            step    <= '0;
            ack     <= 1'b1;
            ram_we  <= 1'b0;
            reg_we  <= 1'b0;
            reg_num <= 8'hFF;
            ptr     <= '0;
        end else begin
            last_op <= op_vec;
            ram_we  <= 1'b0;
            reg_we  <= 1'b0;
            if (op_select_reg) begin
                reg_num <= gcu_pkg::reg_num_t'(din[7:0] & `GCU_REG_SEL_MASK);
                ack     <= 1'b1;
            end else if (op_write_reg) begin
                // single load pulse per write
                reg_we <= op_new;
                ack    <= 1'b1;
            end else if (op_set_ram_ptr) begin
                ptr <= din;
                ack <= 1'b1;
            end else if (op_write_ram) begin
                if (step_cur == 3'd0) begin
                    ram_we <= 1'b1;
                    ack    <= 1'b0;
                    step   <= 3'd1;
                end else if (step_cur == 3'd1) begin
                    ptr  <= ptr + 16'd1;
                    ack  <= 1'b1;
                    step <= 3'd2;
                end else begin
                    ack <= 1'b1;
                end
            end else if (rd_op) begin
                if (step_cur == 3'd0) begin
                    ack  <= 1'b0;
                    step <= 3'd1;
                end else if (step_cur < rd_last) begin
                    step <= step + 3'd1;
                end else if (step_cur == rd_last) begin
                    ack  <= 1'b1;
                    step <= rd_last + 3'd1;
                end else begin
                    ack <= 1'b1;
                end
            end else begin
                ack  <= 1'b1;
                step <= '0;
            end
        end
    end

    // address and data capture
    always_ff @(posedge CLK96) begin
        if (op_write_ram && step_cur == 3'd0) begin
            ram_addr <= ptr_addr;
            ram_din  <= din;
        end else if (rd_op && step_cur == 3'd0) begin
            // low half sits one word above the pointer
            ram_addr <= ptr_addr + gcu_pkg::vram_addr_t'(op_read_ram_l);
        end
        if (rd_op && step_cur == rd_last) begin
            dout <= ram_dout;
        end
        if (op_write_reg) begin
            reg_wr_data <= din;
        end
    end

    a_op_onehot: assert property (@(posedge CLK96) disable iff (RESET96)
        $onehot0(op_vec));

    a_we_pulse: assert property (@(posedge CLK96) disable iff (RESET96)
        ram_we |=> !ram_we);

endmodule

//--- logic/gcu_defs.svh
////////////////////////////////////////
// gcu register numbers, masks and
// video RAM region bounds
////////////////////////////////////////
`ifndef GCU_DEFS_SVH
`define GCU_DEFS_SVH

// register select
`define GCU_REG_SEL_MASK     8'h8F
`define GCU_REG_ALIAS_BIT    8'h80
`define GCU_REG_INIT_V       8'h0E
`define GCU_REG_VINT_ACK     8'h0F
`define GCU_REG_VINT_ACK_ALT 8'h8F

// cpu pointer to word address
`define GCU_PTR_MASK         16'h1FFF

// line where vint is forced low
`define GCU_VINT_LINE        9'h0E6

// region bounds inside the main RAM
`define GCU_SCR0_BASE        13'h0000
`define GCU_SCR1_BASE        13'h0800
`define GCU_SCR2_BASE        13'h1000
`define GCU_SPR_BASE         13'h1800
`define GCU_SPR_END          13'h1C00

// wait states between read address and dout load
`define GCU_READ_WAIT        2

`endif

//--- logic/gcu_dpram.sv
////////////////////////////////////////
// simple dual port RAM, registered read
////////////////////////////////////////
`timescale 1ns/100ps

module gcu_dpram #(
    parameter int addr_width = 13
) (
    input  logic                    CLK96,
    input  logic [addr_width-1:0]   wr_addr,
    input  gcu_pkg::vram_word_t     wr_data,
    input  logic                    we,
    input  logic [addr_width-1:0]   rd_addr,
    output gcu_pkg::vram_word_t     rd_data
);

    localparam int depth = 2 ** addr_width;

    gcu_pkg::vram_word_t mem [depth];

    always_ff @(posedge CLK96) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // data appears one cycle after the address
    always_ff @(posedge CLK96) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- logic/gcu_pkg.sv
////////////////////////////////////////
// gcu shared types for addresses,
// data words and beam counters
////////////////////////////////////////
package gcu_pkg;

    // main video RAM word address
    typedef logic [12:0] vram_addr_t;

    // RAM and cpu bus data word
    typedef logic [15:0] vram_word_t;

    // word address inside one scroll layer copy
    typedef logic [10:0] layer_addr_t;

    // word address inside the sprite copy
    typedef logic [9:0] sprite_addr_t;

    // selected register number after masking
    typedef logic [7:0] reg_num_t;

    // one scroll or control register value
    typedef logic [15:0] scroll_word_t;

    // horizontal or vertical beam position
    typedef logic [8:0] beam_t;

endpackage

//--- logic/gcu_scroll_regs.sv
////////////////////////////////////////
// gcu scroll and vertical control regs
////////////////////////////////////////
`timescale 1ns/100ps
`include "gcu_defs.svh"

module gcu_scroll_regs (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  gcu_pkg::reg_num_t     reg_num,
    input  gcu_pkg::scroll_word_t reg_wr_data,
    input  logic                  reg_we,
    output gcu_pkg::scroll_word_t bg_scroll_x,
    output gcu_pkg::scroll_word_t bg_scroll_y,
    output gcu_pkg::scroll_word_t fg_scroll_x,
    output gcu_pkg::scroll_word_t fg_scroll_y,
    output gcu_pkg::scroll_word_t txt_scroll_x,
    output gcu_pkg::scroll_word_t txt_scroll_y,
    output gcu_pkg::scroll_word_t spr_scroll_x,
    output gcu_pkg::scroll_word_t spr_scroll_y,
    output gcu_pkg::scroll_word_t init_v_ctrl
);

    gcu_pkg::reg_num_t reg_base;
    gcu_pkg::reg_num_t reg_idx;

    // 0x80-0x87 fold onto 0x00-0x07, nothing else aliases
    assign reg_base = reg_num & ~`GCU_REG_ALIAS_BIT;
    assign reg_idx  = (reg_base < 8'h08) ? reg_base : reg_num;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            bg_scroll_x  <= '0;
            bg_scroll_y  <= '0;
            fg_scroll_x  <= '0;
            fg_scroll_y  <= '0;
            txt_scroll_x <= '0;
            txt_scroll_y <= '0;
            spr_scroll_x <= '0;
            spr_scroll_y <= '0;
            init_v_ctrl  <= '0;
        end else if (reg_we) begin
            case (reg_idx)
                8'h00:           bg_scroll_x  <= reg_wr_data;
                8'h01:           bg_scroll_y  <= reg_wr_data;
                8'h02:           fg_scroll_x  <= reg_wr_data;
                8'h03:           fg_scroll_y  <= reg_wr_data;
                8'h04:           txt_scroll_x <= reg_wr_data;
                8'h05:           txt_scroll_y <= reg_wr_data;
                8'h06:           spr_scroll_x <= reg_wr_data;
                8'h07:           spr_scroll_y <= reg_wr_data;
                `GCU_REG_INIT_V: init_v_ctrl  <= reg_wr_data;
                default: ;
            endcase
        end
    end

endmodule

//--- logic/gcu_top.sv
////////////////////////////////////////
// gcu top, cpu bus, registers, timing
////////////////////////////////////////
`timescale 1ns/100ps

module gcu_top (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  op_select_reg,
    input  logic                  op_write_reg,
    input  logic                  op_write_ram,
    input  logic                  op_read_ram_h,
    input  logic                  op_read_ram_l,
    input  logic                  op_set_ram_ptr,
    input  gcu_pkg::vram_word_t   din,
    output gcu_pkg::vram_word_t   dout,
    output logic                  ack,
    input  gcu_pkg::beam_t        h,
    input  gcu_pkg::beam_t        v,
    input  gcu_pkg::beam_t        hs_start,
    input  gcu_pkg::beam_t        hs_end,
    input  gcu_pkg::beam_t        vs_start,
    input  gcu_pkg::beam_t        vs_end,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  fblank,
    output logic                  vint,
    output gcu_pkg::scroll_word_t bg_scroll_x,
    output gcu_pkg::scroll_word_t bg_scroll_y,
    output gcu_pkg::scroll_word_t fg_scroll_x,
    output gcu_pkg::scroll_word_t fg_scroll_y,
    output gcu_pkg::scroll_word_t txt_scroll_x,
    output gcu_pkg::scroll_word_t txt_scroll_y,
    output gcu_pkg::scroll_word_t spr_scroll_x,
    output gcu_pkg::scroll_word_t spr_scroll_y,
    output gcu_pkg::scroll_word_t init_v_ctrl,
    input  gcu_pkg::layer_addr_t  scr0_addr,
    input  gcu_pkg::layer_addr_t  scr1_addr,
    input  gcu_pkg::layer_addr_t  scr2_addr,
    input  gcu_pkg::sprite_addr_t spr_addr,
    output gcu_pkg::vram_word_t   scr0_data,
    output gcu_pkg::vram_word_t   scr1_data,
    output gcu_pkg::vram_word_t   scr2_data,
    output gcu_pkg::vram_word_t   spr_data
);

    gcu_pkg::vram_addr_t ram_addr;
    gcu_pkg::vram_word_t ram_din;
    gcu_pkg::vram_word_t ram_dout;
    logic                ram_we;
    gcu_pkg::reg_num_t   reg_num;
    gcu_pkg::vram_word_t reg_wr_data;
    logic                reg_we;

    gcu_bus_ctrl u_bus_ctrl (
        .CLK96(CLK96), .RESET96(RESET96),
        .op_select_reg(op_select_reg), .op_write_reg(op_write_reg),
        .op_write_ram(op_write_ram), .op_read_ram_h(op_read_ram_h),
        .op_read_ram_l(op_read_ram_l), .op_set_ram_ptr(op_set_ram_ptr),
        .din(din), .dout(dout), .ack(ack),
        .ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we), .ram_dout(ram_dout),
        .reg_num(reg_num), .reg_wr_data(reg_wr_data), .reg_we(reg_we)
    );

    gcu_scroll_regs u_scroll_regs (
        .CLK96(CLK96), .RESET96(RESET96),
        .reg_num(reg_num), .reg_wr_data(reg_wr_data), .reg_we(reg_we),
        .bg_scroll_x(bg_scroll_x), .bg_scroll_y(bg_scroll_y),
        .fg_scroll_x(fg_scroll_x), .fg_scroll_y(fg_scroll_y),
        .txt_scroll_x(txt_scroll_x), .txt_scroll_y(txt_scroll_y),
        .spr_scroll_x(spr_scroll_x), .spr_scroll_y(spr_scroll_y),
        .init_v_ctrl(init_v_ctrl)
    );

    gcu_video_timing u_video_timing (
        .h(h), .v(v), .hs_start(hs_start), .hs_end(hs_end),
        .vs_start(vs_start), .vs_end(vs_end),
        .RESET96(RESET96), .reg_num(reg_num),
        .hsync(hsync), .vsync(vsync), .fblank(fblank), .vint(vint)
    );

    gcu_vram_bank u_vram_bank (
        .CLK96(CLK96),
        .ram_addr(ram_addr), .ram_din(ram_din), .ram_we(ram_we), .ram_dout(ram_dout),
        .scr0_addr(scr0_addr), .scr1_addr(scr1_addr),
        .scr2_addr(scr2_addr), .spr_addr(spr_addr),
        .scr0_data(scr0_data), .scr1_data(scr1_data),
        .scr2_data(scr2_data), .spr_data(spr_data)
    );

endmodule

//--- logic/gcu_video_timing.sv
////////////////////////////////////////
// gcu sync, blank and vint generation
////////////////////////////////////////
`timescale 1ns/100ps
`include "gcu_defs.svh"

module gcu_video_timing (
    input  gcu_pkg::beam_t    h,
    input  gcu_pkg::beam_t    v,
    input  gcu_pkg::beam_t    hs_start,
    input  gcu_pkg::beam_t    hs_end,
    input  gcu_pkg::beam_t    vs_start,
    input  gcu_pkg::beam_t    vs_end,
    input  logic              RESET96,
    input  gcu_pkg::reg_num_t reg_num,
    output logic              hsync,
    output logic              vsync,
    output logic              fblank,
    output logic              vint
);

    logic vint_hold;

    // syncs are active low
    assign hsync  = !(h > hs_start && h < hs_end);
    assign vsync  = !(v >= vs_start && v <= vs_end);
    assign fblank = hsync && vsync;

    // held low on the trigger line or while the cpu acknowledges
    assign vint_hold = (v == `GCU_VINT_LINE)
                    || (reg_num == `GCU_REG_INIT_V)
                    || (reg_num == `GCU_REG_VINT_ACK)
                    || (reg_num == `GCU_REG_VINT_ACK_ALT);

    assign vint = !(vint_hold || RESET96);

endmodule

//--- logic/gcu_vram_bank.sv
////////////////////////////////////////
// gcu main video RAM plus per-region
// copies for layer and sprite readers
////////////////////////////////////////
`timescale 1ns/100ps
`include "gcu_defs.svh"

module gcu_vram_bank (
    input  logic                  CLK96,
    input  gcu_pkg::vram_addr_t   ram_addr,
    input  gcu_pkg::vram_word_t   ram_din,
    input  logic                  ram_we,
    output gcu_pkg::vram_word_t   ram_dout,
    input  gcu_pkg::layer_addr_t  scr0_addr,
    input  gcu_pkg::layer_addr_t  scr1_addr,
    input  gcu_pkg::layer_addr_t  scr2_addr,
    input  gcu_pkg::sprite_addr_t spr_addr,
    output gcu_pkg::vram_word_t   scr0_data,
    output gcu_pkg::vram_word_t   scr1_data,
    output gcu_pkg::vram_word_t   scr2_data,
    output gcu_pkg::vram_word_t   spr_data
);

    logic                  scr0_we;
    logic                  scr1_we;
    logic                  scr2_we;
    logic                  spr_we;
    gcu_pkg::layer_addr_t  layer_wr_addr;
    gcu_pkg::sprite_addr_t spr_wr_addr;

    function automatic logic in_region(gcu_pkg::vram_addr_t a,
                                       gcu_pkg::vram_addr_t lo,
                                       gcu_pkg::vram_addr_t hi);
        return (a >= lo) && (a < hi);
    endfunction

    // region bases are aligned so the low bits give the offset
    assign layer_wr_addr = gcu_pkg::layer_addr_t'(ram_addr);
    assign spr_wr_addr   = gcu_pkg::sprite_addr_t'(ram_addr);

    assign scr0_we = ram_we && in_region(ram_addr, `GCU_SCR0_BASE, `GCU_SCR1_BASE);
    assign scr1_we = ram_we && in_region(ram_addr, `GCU_SCR1_BASE, `GCU_SCR2_BASE);
    assign scr2_we = ram_we && in_region(ram_addr, `GCU_SCR2_BASE, `GCU_SPR_BASE);
    assign spr_we  = ram_we && in_region(ram_addr, `GCU_SPR_BASE, `GCU_SPR_END);

    // full copy that the cpu reads back
    gcu_dpram #(.addr_width(13)) u_main (
        .CLK96(CLK96), .wr_addr(ram_addr), .wr_data(ram_din), .we(ram_we),
        .rd_addr(ram_addr), .rd_data(ram_dout)
    );

    gcu_dpram #(.addr_width(11)) u_scr0 (
        .CLK96(CLK96), .wr_addr(layer_wr_addr), .wr_data(ram_din), .we(scr0_we),
        .rd_addr(scr0_addr), .rd_data(scr0_data)
    );

    gcu_dpram #(.addr_width(11)) u_scr1 (
        .CLK96(CLK96), .wr_addr(layer_wr_addr), .wr_data(ram_din), .we(scr1_we),
        .rd_addr(scr1_addr), .rd_data(scr1_data)
    );

    gcu_dpram #(.addr_width(11)) u_scr2 (
        .CLK96(CLK96), .wr_addr(layer_wr_addr), .wr_data(ram_din), .we(scr2_we),
        .rd_addr(scr2_addr), .rd_data(scr2_data)
    );

    gcu_dpram #(.addr_width(10)) u_spr (
        .CLK96(CLK96), .wr_addr(spr_wr_addr), .wr_data(ram_din), .we(spr_we),
        .rd_addr(spr_addr), .rd_data(spr_data)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the gcu testbench with Verilator, run it, then look for the pass line
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module gcu_tb \
    -o gcu_sim > build.log 2>&1 \
    && ./obj_dir/gcu_sim > sim.log 2>&1 \
    && grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- sim/gcu_checker.sv
////////////////////////////////////////
// gcu checker, compares DUT outputs on
// request and watches RAM ack timing
////////////////////////////////////////
`timescale 1ns/100ps
`include "gcu_defs.svh"

module gcu_checker (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  op_write_ram,
    input  logic                  op_read_ram_h,
    input  logic                  op_read_ram_l,
    input  logic                  ack,
    input  gcu_pkg::vram_word_t   dout,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  fblank,
    input  logic                  vint,
    input  gcu_pkg::scroll_word_t bg_scroll_x,
    input  gcu_pkg::scroll_word_t bg_scroll_y,
    input  gcu_pkg::scroll_word_t fg_scroll_x,
    input  gcu_pkg::scroll_word_t fg_scroll_y,
    input  gcu_pkg::scroll_word_t txt_scroll_x,
    input  gcu_pkg::scroll_word_t txt_scroll_y,
    input  gcu_pkg::scroll_word_t spr_scroll_x,
    input  gcu_pkg::scroll_word_t spr_scroll_y,
    input  gcu_pkg::scroll_word_t init_v_ctrl,
    input  gcu_pkg::vram_word_t   scr0_data,
    input  gcu_pkg::vram_word_t   scr1_data,
    input  gcu_pkg::vram_word_t   scr2_data,
    input  gcu_pkg::vram_word_t   spr_data,
    input  logic                  chk_strobe,
    input  logic [3:0]            chk_kind,
    input  logic [31:0]           chk_arg,
    input  logic [15:0]           chk_exp,
    output int                    err_count,
    output int                    test_count
);

    int   errors = 0;
    int   tests  = 0;
    int   errs_before;
    logic rd_now;
    logic wr_prev  = 1'b0;
    logic rd_prev  = 1'b0;
    logic ram_busy = 1'b0;
    logic busy_rd;
    int   busy_cycles;
    int   want_cycles;

    assign err_count  = errors;
    assign test_count = tests;

    function automatic string kind_name(input logic [3:0] kind);
        case (kind)
            4'h0: return "reset state";
            4'h5: return "read high";
            4'h6: return "read low";
            4'h7: return "register";
            4'h8: return "renderer port";
            4'h9: return "sync and vint";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input int idx, input logic [15:0] exp);
        case (idx)
            0: check_val("bg_scroll_x", bg_scroll_x, exp);
            1: check_val("bg_scroll_y", bg_scroll_y, exp);
            2: check_val("fg_scroll_x", fg_scroll_x, exp);
            3: check_val("fg_scroll_y", fg_scroll_y, exp);
            4: check_val("txt_scroll_x", txt_scroll_x, exp);
            5: check_val("txt_scroll_y", txt_scroll_y, exp);
            6: check_val("spr_scroll_x", spr_scroll_x, exp);
            7: check_val("spr_scroll_y", spr_scroll_y, exp);
            8: check_val("init_v_ctrl", init_v_ctrl, exp);
            default: begin
                errors++;
                $display("no register output with index %0d at t=%0t", idx, $time);
            end
        endcase
    endtask

    task automatic check_render(input logic [1:0] port, input logic [15:0] exp);
        case (port)
            2'd0: check_val("scr0_data", scr0_data, exp);
            2'd1: check_val("scr1_data", scr1_data, exp);
            2'd2: check_val("scr2_data", scr2_data, exp);
            default: check_val("spr_data", spr_data, exp);
        endcase
    endtask

    always @(posedge CLK96) begin
        // ack must come back a fixed number of edges after a RAM op starts
        rd_now = op_read_ram_h | op_read_ram_l;
        if (!RESET96) begin
            if ((op_write_ram && !wr_prev) || (rd_now && !rd_prev)) begin
                ram_busy    = 1'b1;
                busy_rd     = rd_now;
                busy_cycles = 0;
            end else if (ram_busy) begin
                busy_cycles++;
                if (ack) begin
                    ram_busy    = 1'b0;
                    want_cycles = busy_rd ? `GCU_READ_WAIT + 1 : 2;
                    if (busy_cycles != want_cycles) begin
                        errors++;
                        $display("Fail t=%0t ack high after %0d cycles expected %0d",
                                 $time, busy_cycles, want_cycles);
                    end
                end
            end
        end
        wr_prev = op_write_ram;
        rd_prev = rd_now;

        if (chk_strobe) begin
            errs_before = errors;
            case (chk_kind)
                4'h0: begin
                    check_val("ack", 16'(ack), 16'h0001);
                    check_val("vint", 16'(vint), 16'h0000);
                    for (int i = 0; i < 9; i++) begin
                        check_reg(i, 16'h0000);
                    end
                end
                4'h5, 4'h6: check_val("dout", dout, chk_exp);
                4'h7: check_reg(int'(chk_arg[3:0]), chk_exp);
                4'h8: check_render(chk_arg[17:16], chk_exp);
                4'h9: begin
                    // expected bits are vint, fblank, vsync, hsync
                    check_val("hsync", 16'(hsync), 16'(chk_exp[0]));
                    check_val("vsync", 16'(vsync), 16'(chk_exp[1]));
                    check_val("fblank", 16'(fblank), 16'(chk_exp[2]));
                    check_val("vint", 16'(vint), 16'(chk_exp[3]));
                end
                default: begin
                    errors++;
                    $display("check request of unknown kind %h at t=%0t", chk_kind, $time);
                end
            endcase
            tests++;
            if (errors == errs_before) begin
                $display("ok   t=%0t test %0d %s", $time, tests, kind_name(chk_kind));
            end else begin
                $display("bad  t=%0t test %0d %s", $time, tests, kind_name(chk_kind));
            end
        end
    end

endmodule

//--- sim/gcu_stim.txt
// columns: op, argument, expected value (hex). ops: 1 select reg, 2 write reg, 3 set ptr,
// 4 write RAM, 5 read high, 6 read low, 7 check reg (arg index, 8 = init_v_ctrl),
// 8 check renderer (arg[17:16] port, arg[10:0] addr), 9 check sync (arg[24:16] v,
// arg[8:0] h, expected {vint fblank vsync hsync}; H window 16..48, V window 240..247), F end
7 8 0
1 00 0
2 1111 0
7 0 1111
1 03 0
2 3333 0
7 3 3333
7 0 1111
1 85 0
2 5555 0
7 5 5555
7 4 0
7 3 3333
1 05 0
2 6666 0
7 5 6666
1 0E 0
2 0E0E 0
7 8 0E0E
1 8E 0
2 DEAD 0
7 8 0E0E
// main RAM write and read back
3 0100 0
4 1234 0
4 ABCD 0
4 5A5A 0
3 E100 0
5 0 1234
6 0 ABCD
5 0 1234
3 0101 0
6 0 5A5A
// one word per region at the same offset
3 0005 0
4 A000 0
3 0805 0
4 B001 0
3 1005 0
4 C002 0
3 1805 0
4 D003 0
3 07FF 0
4 E004 0
8 00000005 A000
8 00010005 B001
8 00020005 C002
8 00030005 D003
8 000007FF E004
// sync compares and vint
1 00 0
9 00000010 F
9 00000011 A
9 0000002F A
9 00000030 F
9 00F00000 9
9 00F70000 9
9 00F80000 F
9 00E60000 7
1 0F 0
9 00000000 7
1 8F 0
9 00000000 7
1 0E 0
9 00000000 7
1 00 0
9 00000000 F
F 0 0

//--- sim/gcu_tb.sv
////////////////////////////////////////
// gcu testbench, drives cpu bus, beam
// and renderer ports from a step file
////////////////////////////////////////
`timescale 1ns/100ps

module gcu_tb;

    localparam int stim_max     = 128;
    localparam int reset_cycles = 3;

    logic CLK96;
    logic RESET96;

    // cpu bus
    logic                op_select_reg;
    logic                op_write_reg;
    logic                op_write_ram;
    logic                op_read_ram_h;
    logic                op_read_ram_l;
    logic                op_set_ram_ptr;
    gcu_pkg::vram_word_t din;
    gcu_pkg::vram_word_t dout;
    logic                ack;

    // beam counters and sync windows
    gcu_pkg::beam_t h;
    gcu_pkg::beam_t v;
    gcu_pkg::beam_t hs_start;
    gcu_pkg::beam_t hs_end;
    gcu_pkg::beam_t vs_start;
    gcu_pkg::beam_t vs_end;
    logic           hsync;
    logic           vsync;
    logic           fblank;
    logic           vint;

    gcu_pkg::scroll_word_t bg_scroll_x, bg_scroll_y;
    gcu_pkg::scroll_word_t fg_scroll_x, fg_scroll_y;
    gcu_pkg::scroll_word_t txt_scroll_x, txt_scroll_y;
    gcu_pkg::scroll_word_t spr_scroll_x, spr_scroll_y;
    gcu_pkg::scroll_word_t init_v_ctrl;

    // renderer read ports
    gcu_pkg::layer_addr_t  scr0_addr, scr1_addr, scr2_addr;
    gcu_pkg::sprite_addr_t spr_addr;
    gcu_pkg::vram_word_t   scr0_data, scr1_data, scr2_data, spr_data;

    // check requests to the checker
    logic        chk_strobe;
    logic [3:0]  chk_kind;
    logic [31:0] chk_arg;
    logic [15:0] chk_exp;
    int          err_count;
    int          test_count;

    // three words per step: op, argument, expected
    logic [31:0] stim_mem [stim_max*3];
    int          step_count;
    int          bad_steps   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    gcu_top u_dut (.*);

    gcu_checker u_checker (.*);

    initial begin
        CLK96 = 1'b0;
        forever #10 CLK96 = ~CLK96;
    end

    always @(posedge CLK96) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic int count_steps();
        for (int i = 0; i < stim_max; i++) begin
            if (stim_mem[3*i] === 32'hF) begin
                return i;
            end
        end
        return stim_max;
    endfunction

    task automatic release_ops();
        op_select_reg  <= 1'b0;
        op_write_reg   <= 1'b0;
        op_set_ram_ptr <= 1'b0;
        op_write_ram   <= 1'b0;
        op_read_ram_h  <= 1'b0;
        op_read_ram_l  <= 1'b0;
    endtask

    // hold one op level until ack, then one idle cycle
    task automatic drive_op(input logic [3:0] op, input gcu_pkg::vram_word_t data);
        op_select_reg  <= (op == 4'h1);
        op_write_reg   <= (op == 4'h2);
        op_set_ram_ptr <= (op == 4'h3);
        op_write_ram   <= (op == 4'h4);
        op_read_ram_h  <= (op == 4'h5);
        op_read_ram_l  <= (op == 4'h6);
        din            <= data;
        // first edge with the op active
        @(posedge CLK96);
        do begin
            @(posedge CLK96);
        end while (ack !== 1'b1);
        release_ops();
        @(posedge CLK96);
    endtask

    task automatic request_check(input logic [3:0] kind, input logic [31:0] arg,
                                 input logic [15:0] exp);
        chk_kind   <= kind;
        chk_arg    <= arg;
        chk_exp    <= exp;
        chk_strobe <= 1'b1;
        @(posedge CLK96);
        chk_strobe <= 1'b0;
    endtask

    task automatic set_render_addr(input logic [1:0] port, input logic [10:0] addr);
        case (port)
            2'd0: scr0_addr <= addr;
            2'd1: scr1_addr <= addr;
            2'd2: scr2_addr <= addr;
            default: spr_addr <= addr[9:0];
        endcase
    endtask

    task automatic run_step(input int idx, input logic [3:0] op, input logic [31:0] arg,
                            input logic [15:0] exp);
        case (op)
            4'h1, 4'h2, 4'h3, 4'h4: drive_op(op, arg[15:0]);
            4'h5, 4'h6: begin
                drive_op(op, 16'h0000);
                request_check(op, arg, exp);
            end
            4'h7: request_check(op, arg, exp);
            4'h8: begin
                set_render_addr(arg[17:16], arg[10:0]);
                // registered read, data one cycle later
                @(posedge CLK96);
                request_check(op, arg, exp);
            end
            4'h9: begin
                v <= arg[24:16];
                h <= arg[8:0];
                @(posedge CLK96);
                request_check(op, arg, exp);
            end
            default: begin
                bad_steps++;
                $display("stimulus step %0d has an unknown op code %h", idx, op);
            end
        endcase
    endtask

    initial begin
        RESET96    = 1'b1;
        release_ops();
        din        = '0;
        h          = '0;
        v          = '0;
        hs_start   = 9'd16;
        hs_end     = 9'd48;
        vs_start   = 9'd240;
        vs_end     = 9'd247;
        scr0_addr  = '0;
        scr1_addr  = '0;
        scr2_addr  = '0;
        spr_addr   = '0;
        chk_strobe = 1'b0;
        chk_kind   = '0;
        chk_arg    = '0;
        chk_exp    = '0;
        $readmemh("sim/gcu_stim.txt", stim_mem);
        step_count  = count_steps();
        cycle_limit = step_count * 8 + reset_cycles;

        // reset state is sampled on the last reset edge
        repeat (reset_cycles - 1) @(posedge CLK96);
        chk_kind   <= 4'h0;
        chk_strobe <= 1'b1;
        @(posedge CLK96);
        RESET96    <= 1'b0;
        chk_strobe <= 1'b0;

        for (int i = 0; i < step_count; i++) begin
            run_step(i, stim_mem[3*i][3:0], stim_mem[3*i+1], stim_mem[3*i+2][15:0]);
        end
        @(posedge CLK96);

        $display("tests %0d, errors %0d, bad steps %0d", test_count, err_count, bad_steps);
        if (err_count == 0 && bad_steps == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // run limit from the step count
    initial begin
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/gcu_pkg.sv
logic/gcu_dpram.sv
logic/gcu_vram_bank.sv
logic/gcu_bus_ctrl.sv
logic/gcu_scroll_regs.sv
logic/gcu_video_timing.sv
logic/gcu_top.sv
sim/gcu_checker.sv
sim/gcu_tb.sv
